//--- hdl/ooo_cfg.svh
/*
  Build-time sizing for the commit subsystem.
  OOO_ROB_DEPTH must be a power of two; it sets both buffer entries and credits.
*/
`ifndef OOO_CFG_SVH
`define OOO_CFG_SVH

// Reorder buffer entries, also the number of dispatch credits
`define OOO_ROB_DEPTH 8

// Identical execution lanes behind the dispatcher
`define OOO_NUM_LANES 4

// Operand and result width
`define OOO_DATA_W 16

`endif

//--- hdl/ooo_pkg.sv
/*
  Shared types and the arithmetic rule used by every lane.
  Tag width follows OOO_ROB_DEPTH, so tags wrap exactly at the buffer depth.
*/
`default_nettype none
`include "ooo_cfg.svh"

package ooo_pkg;

  // Entry tag, one value per buffer slot
  typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] tag_t;

  typedef enum logic [1:0] {
    OP_ADD,
    OP_SUB,
    OP_XOR,
    OP_MUL
  } opcode_t;

  // Requested latency, lane takes this plus one cycles
  typedef logic [1:0] lat_t;

  typedef logic [`OOO_DATA_W-1:0] data_t;

  // Payload held in the reorder buffer
  typedef struct packed {
    data_t data;
  } result_t;

  function automatic data_t apply_op(opcode_t op, data_t a, data_t b);
    data_t r;
    r = '0;
    case (op)
      OP_ADD: r = a + b;
      OP_SUB: r = a - b;
      OP_XOR: r = a ^ b;
      // Product truncated to the low data bits
      OP_MUL: r = a * b;
      default: r = '0;
    endcase
    return r;
  endfunction

endpackage

`default_nettype wire

//--- hdl/tag_dispatch.sv
/*
  Accepts one operation per cycle and issues it to the lowest idle lane.
  Tags are sequential modulo the buffer depth; credits cap outstanding tags,
  so the buffer never sees an insert onto a live entry.
*/
`default_nettype none
`include "ooo_cfg.svh"

module tag_dispatch (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      in_valid,
  input  wire ooo_pkg::opcode_t          in_opcode,
  input  wire ooo_pkg::data_t            in_a,
  input  wire ooo_pkg::data_t            in_b,
  input  wire ooo_pkg::lat_t             in_lat,
  output logic                           in_ready,
  input  wire logic [`OOO_NUM_LANES-1:0] lane_idle,
  input  wire logic                      retire,
  output logic [`OOO_NUM_LANES-1:0]      issue_valid,
  output ooo_pkg::tag_t                  issue_tag,
  output ooo_pkg::opcode_t               issue_opcode,
  output ooo_pkg::data_t                 issue_a,
  output ooo_pkg::data_t                 issue_b,
  output ooo_pkg::lat_t                  issue_lat
);

  // One extra bit so the full count fits
  localparam int cred_w = $clog2(`OOO_ROB_DEPTH) + 1;

  logic [cred_w-1:0]         credits;
  ooo_pkg::tag_t             next_tag;
  logic [`OOO_NUM_LANES-1:0] pick;
  logic                      accept;

  // ----------------------------------------------------------
  // Lane selection
  // ----------------------------------------------------------

  // Isolate lowest set bit of the idle mask
  assign pick = lane_idle & (~lane_idle + 1'b1);

  // Need a free slot downstream and somewhere to run
  assign in_ready = (credits != '0) && (|lane_idle);
  assign accept   = in_valid & in_ready;

  assign issue_valid  = {`OOO_NUM_LANES{accept}} & pick;
  // Payload goes to all lanes, only the picked one latches it
  assign issue_tag    = next_tag;
  assign issue_opcode = in_opcode;
  assign issue_a      = in_a;
  assign issue_b      = in_b;
  assign issue_lat    = in_lat;

  // ----------------------------------------------------------
  // Tag and credit tracking
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      next_tag <= '0;
      credits  <= cred_w'(`OOO_ROB_DEPTH);
    end else begin
      // Tag width matches depth, wrap is implicit
      if (accept)
        next_tag <= next_tag + 1'b1;
      // Accept and retire in one cycle cancel out
      case ({accept, retire})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // Retire without an outstanding tag would overflow credits
  a_credit_bound: assert property (@(posedge clk) disable iff (rst)
    credits <= cred_w'(`OOO_ROB_DEPTH));

  a_issue_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(issue_valid));

endmodule

`default_nettype wire

//--- hdl/exec_lane.sv
/*
  One execution lane. Result is computed at issue and released after
  latency field plus one cycles, then held until the arbiter grants it.
  Lane only accepts an issue while idle.
*/
`default_nettype none

module exec_lane (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic             issue_valid,
  input  wire ooo_pkg::tag_t    issue_tag,
  input  wire ooo_pkg::opcode_t issue_opcode,
  input  wire ooo_pkg::data_t   issue_a,
  input  wire ooo_pkg::data_t   issue_b,
  input  wire ooo_pkg::lat_t    issue_lat,
  input  wire logic             grant,
  output logic                  lane_idle,
  output logic                  done_valid,
  output ooo_pkg::tag_t         done_tag,
  output ooo_pkg::data_t        done_data
);

  logic          busy;
  ooo_pkg::lat_t cnt;
  logic          leave;

  // Result handed off to the buffer this edge
  assign leave     = done_valid & grant;
  assign lane_idle = ~busy;

  // Busy from issue edge through grant edge
  always_ff @(posedge clk) begin
    if (rst) begin
      busy       <= 1'b0;
      done_valid <= 1'b0;
      cnt        <= '0;
    end else if (issue_valid) begin
      busy       <= 1'b1;
      done_valid <= 1'b0;
      cnt        <= issue_lat;
    end else if (leave) begin
      busy       <= 1'b0;
      done_valid <= 1'b0;
    end else if (busy && !done_valid) begin
      // Zero count means last cycle of latency
      if (cnt == '0)
        done_valid <= 1'b1;
      else
        cnt <= cnt - 1'b1;
    end
  end

  // Payload latched once per operation
  always_ff @(posedge clk) begin
    if (issue_valid) begin
      done_tag  <= issue_tag;
      done_data <= ooo_pkg::apply_op(issue_opcode, issue_a, issue_b);
    end
  end

  // Dispatcher must only pick idle lanes
  a_no_issue_busy: assert property (@(posedge clk) disable iff (rst)
    issue_valid |-> !busy);

endmodule

`default_nettype wire

//--- hdl/result_arbiter.sv
/*
  Round-robin pick of one finished lane per cycle, combinational path.
  Pointer moves past the granted lane so every lane gets a turn.
  No ready toward the buffer; credits guarantee a free slot.
*/
`default_nettype none
`include "ooo_cfg.svh"

module result_arbiter (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic [`OOO_NUM_LANES-1:0] done_valid,
  input  wire ooo_pkg::tag_t             done_tag [`OOO_NUM_LANES],
  input  wire ooo_pkg::data_t            done_data [`OOO_NUM_LANES],
  output logic [`OOO_NUM_LANES-1:0]      grant,
  output logic                           ins_en,
  output ooo_pkg::tag_t                  ins_idx,
  output ooo_pkg::result_t               ins_msg
);

  localparam int n     = `OOO_NUM_LANES;
  localparam int ptr_w = (n > 1) ? $clog2(n) : 1;

  logic [ptr_w-1:0] ptr;
  logic [ptr_w-1:0] sel;
  logic             any;
  int               probe;

  // First valid lane at or after the pointer
  always_comb begin
    sel   = ptr;
    any   = 1'b0;
    probe = 0;
    for (int i = 0; i < n; i++) begin
      probe = int'(ptr) + i;
      if (probe >= n)
        probe = probe - n;
      if (!any && done_valid[probe]) begin
        any = 1'b1;
        sel = ptr_w'(probe);
      end
    end
  end

  always_comb begin
    grant = '0;
    if (any)
      grant[sel] = 1'b1;
  end

  assign ins_en  = any;
  assign ins_idx = done_tag[sel];
  assign ins_msg = '{data: done_data[sel]};

  // Step past the winner, wrap at lane count
  always_ff @(posedge clk) begin
    if (rst)
      ptr <= '0;
    else if (any)
      ptr <= (sel == ptr_w'(n - 1)) ? '0 : sel + 1'b1;
  end

  a_grant_legal: assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant) && ((grant & ~done_valid) == '0));

endmodule

`default_nettype wire

//--- hdl/reorder_buffer.sv
/*
  Tag-indexed result store, released strictly in tag order.
  depth must equal the number of tag values. An insert that hits the head
  while commit_ready is high commits at once and is never stored.
*/
`default_nettype none
`include "ooo_cfg.svh"

module reorder_buffer #(
  parameter int  depth = `OOO_ROB_DEPTH,
  parameter type t_msg = ooo_pkg::result_t
) (
  input  wire logic          clk,
  input  wire logic          rst,

  // ----------------------------------------------------------
  // Insert side, from the arbiter
  // ----------------------------------------------------------
  input  wire logic          ins_en,
  input  wire ooo_pkg::tag_t ins_idx,
  input  wire t_msg          ins_msg,

  // ----------------------------------------------------------
  // Commit side
  // ----------------------------------------------------------
  output logic               commit_valid,
  output ooo_pkg::tag_t      commit_tag,
  output t_msg               commit_data,
  input  wire logic          commit_ready,
  output logic               retire
);

  // ----------------------------------------------------------
  // Storage
  // ----------------------------------------------------------

  logic [depth-1:0] ent_val;
  t_msg             ent_msg [depth];

  ooo_pkg::tag_t    head;
  logic             head_hit;
  logic             bypass;
  logic             commit_fire;

  // Insert lands on the slot about to leave
  assign head_hit    = ins_en && (ins_idx == head);
  assign bypass      = head_hit & commit_ready;
  assign commit_fire = commit_valid & commit_ready;

  // Valid flags are the only state needing reset
  always_ff @(posedge clk) begin
    if (rst) begin
      ent_val <= '0;
    end else begin
      if (ins_en && !bypass)
        ent_val[ins_idx] <= 1'b1;
      // Free the head slot, a bypass never set it
      if (commit_fire)
        ent_val[head] <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ins_en && !bypass)
      ent_msg[ins_idx] <= ins_msg;
  end

  // ----------------------------------------------------------
  // In-order release
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst)
      head <= '0;
    else if (commit_fire)
      head <= (head == ooo_pkg::tag_t'(depth - 1)) ? '0 : head + 1'b1;
  end

  assign commit_valid = ent_val[head] | head_hit;
  assign commit_tag   = head;
  // Stored copy preferred, otherwise the arriving result
  assign commit_data  = ent_val[head] ? ent_msg[head] : ins_msg;

  // Credit back to the dispatcher
  assign retire = commit_fire;

  // Credits should keep a live slot from being overwritten
  a_no_overwrite: assert property (@(posedge clk) disable iff (rst)
    ins_en |-> !ent_val[ins_idx]);

endmodule

`default_nettype wire

//--- hdl/ooo_commit_top.sv
/*
  Commit subsystem: dispatcher, execution lanes, result arbiter, reorder buffer.
  Operations commit in acceptance order whatever their latency.
*/
`default_nettype none
`include "ooo_cfg.svh"

module ooo_commit_top (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic             in_valid,
  output logic                  in_ready,
  input  wire ooo_pkg::opcode_t in_opcode,
  input  wire ooo_pkg::data_t   in_a,
  input  wire ooo_pkg::data_t   in_b,
  input  wire ooo_pkg::lat_t    in_lat,
  output logic                  commit_valid,
  input  wire logic             commit_ready,
  output ooo_pkg::tag_t         commit_tag,
  output ooo_pkg::result_t      commit_data
);

  // ----------------------------------------------------------
  // Interconnect
  // ----------------------------------------------------------

  // Dispatch to lanes
  logic [`OOO_NUM_LANES-1:0] issue_valid;
  logic [`OOO_NUM_LANES-1:0] lane_idle;
  ooo_pkg::tag_t             issue_tag;
  ooo_pkg::opcode_t          issue_opcode;
  ooo_pkg::data_t            issue_a;
  ooo_pkg::data_t            issue_b;
  ooo_pkg::lat_t             issue_lat;

  // Lanes to arbiter
  logic [`OOO_NUM_LANES-1:0] done_valid;
  logic [`OOO_NUM_LANES-1:0] grant;
  ooo_pkg::tag_t             done_tag [`OOO_NUM_LANES];
  ooo_pkg::data_t            done_data [`OOO_NUM_LANES];

  // Arbiter to buffer, buffer back to dispatch
  logic                      ins_en;
  ooo_pkg::tag_t             ins_idx;
  ooo_pkg::result_t          ins_msg;
  logic                      retire;

  tag_dispatch dispatch_i (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .in_opcode    (in_opcode),
    .in_a         (in_a),
    .in_b         (in_b),
    .in_lat       (in_lat),
    .in_ready     (in_ready),
    .lane_idle    (lane_idle),
    .retire       (retire),
    .issue_valid  (issue_valid),
    .issue_tag    (issue_tag),
    .issue_opcode (issue_opcode),
    .issue_a      (issue_a),
    .issue_b      (issue_b),
    .issue_lat    (issue_lat)
  );

  for (genvar g = 0; g < `OOO_NUM_LANES; g++) begin : g_lane
    exec_lane lane_i (
      .clk          (clk),
      .rst          (rst),
      .issue_valid  (issue_valid[g]),
      .issue_tag    (issue_tag),
      .issue_opcode (issue_opcode),
      .issue_a      (issue_a),
      .issue_b      (issue_b),
      .issue_lat    (issue_lat),
      .grant        (grant[g]),
      .lane_idle    (lane_idle[g]),
      .done_valid   (done_valid[g]),
      .done_tag     (done_tag[g]),
      .done_data    (done_data[g])
    );
  end

  result_arbiter arbiter_i (
    .clk        (clk),
    .rst        (rst),
    .done_valid (done_valid),
    .done_tag   (done_tag),
    .done_data  (done_data),
    .grant      (grant),
    .ins_en     (ins_en),
    .ins_idx    (ins_idx),
    .ins_msg    (ins_msg)
  );

  reorder_buffer #(
    .depth (`OOO_ROB_DEPTH),
    .t_msg (ooo_pkg::result_t)
  ) rob_i (
    .clk          (clk),
    .rst          (rst),
    .ins_en       (ins_en),
    .ins_idx      (ins_idx),
    .ins_msg      (ins_msg),
    .commit_valid (commit_valid),
    .commit_tag   (commit_tag),
    .commit_data  (commit_data),
    .commit_ready (commit_ready),
    .retire       (retire)
  );

endmodule

`default_nettype wire

//--- test/tb_ooo_commit.sv
/*
  Testbench for ooo_commit_top. Expected results come from a local model queue.
  Inputs change on falling edges and checks run at rising edges.
  Every wait is bounded, so a lost operation ends the run as a failure.
*/
`default_nettype none
`include "ooo_cfg.svh"

module tb_ooo_commit;

  logic             clk;
  logic             rst;
  logic             in_valid;
  logic             in_ready;
  ooo_pkg::opcode_t in_opcode;
  ooo_pkg::data_t   in_a;
  ooo_pkg::data_t   in_b;
  ooo_pkg::lat_t    in_lat;
  logic             commit_valid;
  logic             commit_ready;
  ooo_pkg::tag_t    commit_tag;
  ooo_pkg::result_t commit_data;

  ooo_pkg::data_t   exp_q [$];
  ooo_pkg::tag_t    exp_tag;
  logic [31:0]      lfsr;
  int               errors;
  int               base_err;
  int               accepts;
  int               commits;
  int               tests;
  string            cur_test;

  ooo_commit_top dut_i (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .in_opcode    (in_opcode),
    .in_a         (in_a),
    .in_b         (in_b),
    .in_lat       (in_lat),
    .commit_valid (commit_valid),
    .commit_ready (commit_ready),
    .commit_tag   (commit_tag),
    .commit_data  (commit_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ------------------------------------------------------------
  // Model and random source
  // ------------------------------------------------------------

  // Opcode rule done in 32-bit arithmetic, then cut to data width
  function automatic ooo_pkg::data_t model_result(ooo_pkg::opcode_t op,
                                                  ooo_pkg::data_t a, ooo_pkg::data_t b);
    logic [31:0] wide;
    case (op)
      ooo_pkg::OP_ADD: wide = 32'(a) + 32'(b);
      // Two's complement subtract
      ooo_pkg::OP_SUB: wide = 32'(a) + 32'(~b) + 32'd1;
      ooo_pkg::OP_XOR: wide = 32'(a ^ b);
      default:         wide = 32'(a) * 32'(b);
    endcase
    return wide[`OOO_DATA_W-1:0];
  endfunction

  // Fibonacci LFSR on taps 32 22 2 1 stepping once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  // ------------------------------------------------------------
  // Scoreboard at rising edges
  // ------------------------------------------------------------

  always @(posedge clk) begin
    if (!rst) begin
      if (in_valid && in_ready) begin
        exp_q.push_back(model_result(in_opcode, in_a, in_b));
        accepts++;
      end
      if (commit_valid && commit_ready) begin
        commits++;
        assert (exp_q.size() > 0) else begin
          $display("%s: commit arrived with no operation outstanding", cur_test);
          errors++;
        end
        assert (commit_tag == exp_tag) else begin
          $display("FAIL %s tag: expected %0d, actual %0d", cur_test, exp_tag, commit_tag);
          errors++;
        end
        if (exp_q.size() > 0) begin
          assert (commit_data.data == exp_q[0]) else begin
            $display("FAIL %s data: expected %h, actual %h",
                     cur_test, exp_q[0], commit_data.data);
            errors++;
          end
          void'(exp_q.pop_front());
        end
        exp_tag = exp_tag + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // Stimulus helpers, all entered on a falling edge
  // ------------------------------------------------------------

  task automatic start_test(input string name);
    cur_test = name;
    base_err = errors;
    tests++;
  endtask

  task automatic report_test();
    $display("%s: %s (%0d errors)", cur_test,
             (errors == base_err) ? "ok" : "bad", errors - base_err);
  endtask

  // Transfer lands on the rising edge after in_ready is seen
  task automatic send_op(input ooo_pkg::opcode_t op, input ooo_pkg::data_t a,
                         input ooo_pkg::data_t b, input ooo_pkg::lat_t lat);
    int t;
    in_valid  = 1'b1;
    in_opcode = op;
    in_a      = a;
    in_b      = b;
    in_lat    = lat;
    t = 0;
    while (!in_ready && t < 100) begin
      @(negedge clk);
      t++;
    end
    assert (in_ready) else begin
      $display("%s: in_ready never rose for a pending operation", cur_test);
      errors++;
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic wait_drain(input int limit);
    int t;
    t = 0;
    while (commits != accepts && t < limit) begin
      @(negedge clk);
      t++;
    end
    assert (commits == accepts) else begin
      $display("%s: timed out with %0d operations never committed",
               cur_test, accepts - commits);
      errors++;
    end
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------

  initial begin
    int base;
    int issued;
    int guard;
    logic took;
    rst          = 1'b1;
    in_valid     = 1'b0;
    in_opcode    = ooo_pkg::OP_ADD;
    in_a         = '0;
    in_b         = '0;
    in_lat       = '0;
    commit_ready = 1'b1;
    lfsr         = 32'h76b7;
    exp_tag      = '0;
    errors       = 0;
    accepts      = 0;
    commits      = 0;
    tests        = 0;
    cur_test     = "reset";
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    start_test("single_add");
    assert (!commit_valid) else begin
      $display("FAIL %s commit_valid: expected 0, actual 1", cur_test);
      errors++;
    end
    send_op(ooo_pkg::OP_ADD, 16'h0012, 16'h0034, 2'd0);
    wait_drain(50);
    report_test();

    // Long first, short second, so lanes finish out of order
    start_test("out_of_order");
    send_op(ooo_pkg::OP_ADD, 16'h1000, 16'h0001, 2'd3);
    send_op(ooo_pkg::OP_SUB, 16'h2000, 16'h0002, 2'd0);
    send_op(ooo_pkg::OP_XOR, 16'h3000, 16'h0003, 2'd2);
    send_op(ooo_pkg::OP_MUL, 16'h0004, 16'h0005, 2'd1);
    wait_drain(100);
    report_test();

    start_test("opcodes");
    send_op(ooo_pkg::OP_ADD, 16'hffff, 16'h0003, 2'd1);
    send_op(ooo_pkg::OP_SUB, 16'h0002, 16'h0007, 2'd0);
    send_op(ooo_pkg::OP_XOR, 16'ha5a5, 16'hffff, 2'd2);
    send_op(ooo_pkg::OP_MUL, 16'h8001, 16'h0003, 2'd3);
    send_op(ooo_pkg::OP_MUL, 16'hffff, 16'hffff, 2'd0);
    wait_drain(100);
    report_test();

    // Buffer fills, credits run out
    start_test("backpressure");
    commit_ready = 1'b0;
    base         = accepts;
    in_valid     = 1'b1;
    in_opcode    = ooo_pkg::OP_ADD;
    in_b         = 16'h0100;
    guard        = 0;
    while (accepts - base < `OOO_ROB_DEPTH && guard < 200) begin
      in_a   = 16'(accepts - base);
      in_lat = ooo_pkg::lat_t'(accepts - base);
      @(negedge clk);
      guard++;
    end
    repeat (20) begin
      @(negedge clk);
      assert (!in_ready) else begin
        $display("FAIL %s in_ready: expected 0, actual 1", cur_test);
        errors++;
      end
    end
    assert (accepts - base == `OOO_ROB_DEPTH) else begin
      $display("FAIL %s accepted: expected %0d, actual %0d",
               cur_test, `OOO_ROB_DEPTH, accepts - base);
      errors++;
    end
    in_valid     = 1'b0;
    commit_ready = 1'b1;
    wait_drain(200);
    report_test();

    start_test("random_stream");
    base   = commits;
    issued = 0;
    guard  = 0;
    took   = 1'b0;
    while ((issued < 200 || in_valid) && guard < 20000) begin
      @(negedge clk);
      guard++;
      if (in_valid && took)
        in_valid = 1'b0;
      // Ready three cycles out of four on average
      commit_ready = (rand_bits(2) != 0);
      if (!in_valid && issued < 200 && rand_bits(1) == 1) begin
        in_opcode = ooo_pkg::opcode_t'(rand_bits(2));
        in_a      = ooo_pkg::data_t'(rand_bits(`OOO_DATA_W));
        in_b      = ooo_pkg::data_t'(rand_bits(`OOO_DATA_W));
        in_lat    = ooo_pkg::lat_t'(rand_bits(2));
        in_valid  = 1'b1;
        issued++;
      end
      // in_ready only moves on rising edges
      took = in_valid && in_ready;
    end
    assert (issued == 200 && !in_valid) else begin
      $display("%s: stimulus loop timed out after %0d operations", cur_test, issued);
      errors++;
    end
    in_valid     = 1'b0;
    commit_ready = 1'b1;
    wait_drain(500);
    assert (commits - base == 200) else begin
      $display("FAIL %s committed: expected 200, actual %0d", cur_test, commits - base);
      errors++;
    end
    report_test();

    $display("%0d tests run, %0d checks failed", tests, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+hdl
hdl/ooo_pkg.sv
hdl/tag_dispatch.sv
hdl/exec_lane.sv
hdl/result_arbiter.sv
hdl/reorder_buffer.sv
hdl/ooo_commit_top.sv
test/tb_ooo_commit.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_ooo_commit
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Done: errors found

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	@$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
